// ==== compile.f ====
+incdir+include
verilog/noc_flit_pkg.sv
verilog/noc_route_pkg.sv
verilog/xy_route_compute.sv
verilog/circular_buffer.sv
verilog/input_buffer.sv
verilog/downstream_vc_allocator.sv
verilog/router_input_port.sv
verification/tb_router_input_port.sv

// ==== include/noc_config.svh ====
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Depth of the input FIFO in flits
`define NOC_BUFFER_SIZE 8
// Flits still in flight when on/off goes low upstream
`define NOC_PIPELINE_DEPTH 5

`define NOC_VC_NUM 4         // Virtual channels on the downstream link
`define NOC_VC_SIZE 2        // Bits needed to name one of them

`define NOC_PAYLOAD_WIDTH 16 // Flit payload bits
`define NOC_COORD_WIDTH 2    // Bits per mesh coordinate

// Position of this router in the mesh
`define NOC_LOCAL_X 1
`define NOC_LOCAL_Y 1

`endif

// ==== verification/input_port_patterns.txt ====
# op label payload filler vc port  (B: mask in first field, F: on_off full empty request)
# W write, B busy mask, G grant and check, S wait for request, E error pulse, F flags
F 1 0 1 0 0
W 0 a00d 0 0 0
W 1 0 1 0 0
W 1 0 1 0 0
W 2 5a5a 0 0 0
S 0 0 0 0 0
G 0 a00d 0 0 4
G 1 0 1 0 4
G 1 0 1 0 4
G 2 5a5a 0 0 4
W 1 1234 0 0 0
E 0 0 0 0 0
B 3 0 0 0 0
W 0 1207 0 0 0
W 2 0011 0 0 0
S 0 0 0 0 0
G 0 1207 0 2 1
G 2 0011 0 2 1
B f 0 0 0 0
W 0 2302 0 0 0
W 1 0 1 0 0
W 2 0022 0 0 0
F 0 0 0 0 0
G 0 2302 0 2 3
E 0 0 0 0 0
B 7 0 0 0 0
S 0 0 0 0 0
G 0 2302 0 3 3
G 1 0 1 3 3
G 2 0022 0 3 3
B 1 0 0 0 0
W 0 3405 0 0 0
W 1 0 1 0 0
W 1 0 1 0 0
F 0 0 0 1 0
W 1 0 1 0 0
W 1 0 1 0 0
W 1 0 1 0 0
W 1 0 1 0 0
W 2 0044 0 0 0
F 0 1 0 1 0
G 0 3405 0 1 0
G 1 0 1 1 0
G 1 0 1 1 0
G 1 0 1 1 0
G 1 0 1 1 0
G 1 0 1 1 0
G 1 0 1 1 0
G 2 0044 0 1 0
F 1 0 1 0 0

// ==== verification/tb_router_input_port.sv ====
`timescale 1ns/1ps

`include "noc_config.svh"

module tb_router_input_port;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_LINE = 50;
    localparam PATTERN_FILE        = "verification/input_port_patterns.txt";

    logic                      clk;
    logic                      rst;
    logic                      flit_write;
    noc_flit_pkg::flit_label_t in_label;
    noc_flit_pkg::payload_t    in_payload;
    logic                      sw_grant;
    logic [`NOC_VC_NUM-1:0]    vc_busy;
    noc_flit_pkg::flit_label_t out_label;
    noc_flit_pkg::payload_t    out_payload;
    noc_flit_pkg::vc_id_t      out_vc;
    noc_route_pkg::port_t      out_port;
    logic                      switch_request;
    logic                      on_off;
    logic                      is_full;
    logic                      is_empty;
    logic                      error;

    logic [31:0] stim_seed;  // Filler payloads on the write side
    logic [31:0] exp_seed;   // Same sequence replayed for the grants
    int          line_total;

    logic [63:0] op_q [$];
    logic [31:0] f1_q [$];
    logic [31:0] f2_q [$];
    logic [31:0] f3_q [$];
    logic [31:0] f4_q [$];
    logic [31:0] f5_q [$];

    router_input_port i_dut (
        .clk              (clk),
        .rst              (rst),
        .flit_write_i     (flit_write),
        .flit_label_i     (in_label),
        .payload_i        (in_payload),
        .sw_grant_i       (sw_grant),
        .vc_busy_i        (vc_busy),
        .flit_label_o     (out_label),
        .payload_o        (out_payload),
        .vc_id_o          (out_vc),
        .out_port_o       (out_port),
        .switch_request_o (switch_request),
        .on_off_o         (on_off),
        .is_full_o        (is_full),
        .is_empty_o       (is_empty),
        .error_o          (error)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] seed);
        return seed * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper bits of the generator state are the better distributed ones
    function automatic noc_flit_pkg::payload_t filler_payload(input logic [31:0] seed);
        return seed[31 -: `NOC_PAYLOAD_WIDTH];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            fail_run($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
    endtask

    // Operation lines always carry six tokens, comments never parse that far
    task automatic load_patterns();
        int               fd;
        int               n;
        logic [8*120-1:0] line;
        logic [63:0]      op;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [31:0]      f4;
        logic [31:0]      f5;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0)
            fail_run("Cannot open the pattern file verification/input_port_patterns.txt");
        while ($fgets(line, fd) != 0)
        begin
            n = $sscanf(line, "%s %h %h %h %h %h", op, f1, f2, f3, f4, f5);
            if (n == 6 && op != "#")
            begin
                op_q.push_back(op);
                f1_q.push_back(f1);
                f2_q.push_back(f2);
                f3_q.push_back(f3);
                f4_q.push_back(f4);
                f5_q.push_back(f5);
            end
        end
        $fclose(fd);
    endtask

    task automatic write_flit(input logic [31:0] label, input logic [31:0] payload,
                              input logic use_filler);
        noc_flit_pkg::payload_t data;
        data = payload[`NOC_PAYLOAD_WIDTH-1:0];
        if (use_filler)
        begin
            stim_seed = lcg_next(stim_seed);
            data      = filler_payload(stim_seed);
        end
        @(posedge clk);
        flit_write <= 1'b1;
        in_label   <= noc_flit_pkg::flit_label_t'(label[1:0]);
        in_payload <= data;
        @(posedge clk);
        flit_write <= 1'b0;  // The DUT sampled the flit on this edge
    endtask

    task automatic set_busy_mask(input logic [31:0] mask);
        @(posedge clk);
        vc_busy <= mask[`NOC_VC_NUM-1:0];
    endtask

    // A granted flit is already on the outputs in the cycle of the grant
    task automatic grant_and_check(input logic [31:0] label, input logic [31:0] payload,
                                   input logic use_filler, input logic [31:0] vc,
                                   input logic [31:0] port);
        logic [31:0] exp_payload;
        exp_payload = payload;
        if (use_filler)
        begin
            exp_seed    = lcg_next(exp_seed);
            exp_payload = 32'(filler_payload(exp_seed));
        end
        @(posedge clk);
        sw_grant <= 1'b1;
        @(negedge clk);
        check_value("flit_label_o", 32'(out_label), label);
        check_value("payload_o", 32'(out_payload), exp_payload);
        check_value("vc_id_o", 32'(out_vc), vc);
        check_value("out_port_o", 32'(out_port), port);
        @(posedge clk);
        sw_grant <= 1'b0;
    endtask

    task automatic wait_switch_request();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!switch_request && waited < CYCLES_PER_LINE)
        begin
            @(negedge clk);
            waited++;
        end
        if (!switch_request)
            fail_run("switch_request_o never rose while the packet waited for a VC");
    endtask

    task automatic expect_error_pulse();
        @(negedge clk);
        check_value("error_o", 32'(error), 32'd1);
        @(negedge clk);
        check_value("error_o", 32'(error), 32'd0);  // Exactly one cycle wide
    endtask

    task automatic check_flags(input logic exp_on_off, input logic exp_full,
                               input logic exp_empty, input logic exp_request);
        @(negedge clk);
        check_value("on_off_o", 32'(on_off), 32'(exp_on_off));
        check_value("is_full_o", 32'(is_full), 32'(exp_full));
        check_value("is_empty_o", 32'(is_empty), 32'(exp_empty));
        check_value("switch_request_o", 32'(switch_request), 32'(exp_request));
    endtask

    task automatic run_patterns();
        for (int i = 0; i < op_q.size(); i++)
        begin
            case (op_q[i])
                "W": write_flit(f1_q[i], f2_q[i], f3_q[i][0]);
                "B": set_busy_mask(f1_q[i]);
                "G": grant_and_check(f1_q[i], f2_q[i], f3_q[i][0], f4_q[i], f5_q[i]);
                "S": wait_switch_request();
                "E": expect_error_pulse();
                "F": check_flags(f1_q[i][0], f2_q[i][0], f3_q[i][0], f4_q[i][0]);
                default: fail_run($sformatf("Unknown operation on pattern line %0d", i + 1));
            endcase
        end
    endtask

    initial
    begin
        rst        = 1'b1;
        flit_write = 1'b0;
        in_label   = noc_flit_pkg::HEAD;
        in_payload = '0;
        sw_grant   = 1'b0;
        vc_busy    = '0;
        stim_seed  = 32'h4736;
        exp_seed   = 32'h4736;
        load_patterns();
        if (op_q.size() == 0)
            fail_run("The pattern file holds no operations");
        line_total = op_q.size();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        run_patterns();
        $display("*** PASSED ***");
        $finish;
    end

    initial
    begin
        wait (line_total > 0);
        #((line_total * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD);
        fail_run("Timeout: the pattern lines did not finish in the allowed time");
    end

endmodule

// ==== verilog/circular_buffer.sv ====
`timescale 1ns/1ps

`include "noc_config.svh"

module circular_buffer #(
    parameter int BUFFER_SIZE    = `NOC_BUFFER_SIZE,
    parameter int PIPELINE_DEPTH = `NOC_PIPELINE_DEPTH
)(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      write_i,
    input  logic                      read_i,
    input  noc_flit_pkg::flit_label_t flit_label_i,
    input  noc_flit_pkg::payload_t    payload_i,
    output noc_flit_pkg::flit_label_t flit_label_o,
    output noc_flit_pkg::payload_t    payload_o,
    output logic                      is_full_o,
    output logic                      is_empty_o,
    output logic                      on_off_o
);

    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    noc_flit_pkg::flit_label_t label_mem [BUFFER_SIZE];
    noc_flit_pkg::payload_t    payload_mem [BUFFER_SIZE];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_write;
    logic do_read;

    assign do_write = write_i & ~is_full_o;  // A write into a full FIFO is lost
    assign do_read  = read_i & ~is_empty_o;

    assign is_full_o  = (count == CNT_W'(BUFFER_SIZE));
    assign is_empty_o = (count == '0);
    assign on_off_o   = (count < CNT_W'(BUFFER_SIZE - PIPELINE_DEPTH)); // Upstream stops early

    assign flit_label_o = label_mem[rd_ptr];  // Oldest flit is always visible
    assign payload_o    = payload_mem[rd_ptr];

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= (wr_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= (rd_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_write & ~do_read)
                count <= count + 1'b1;
            else if (do_read & ~do_write)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            label_mem[wr_ptr]   <= flit_label_i;
            payload_mem[wr_ptr] <= payload_i;
        end
    end

    // The sender is expected to honour on/off well before the FIFO fills
    a_no_overflow : assert property (@(posedge clk) disable iff (rst) write_i |-> !is_full_o)
        else $error("circular_buffer: write while full");

    a_no_underflow : assert property (@(posedge clk) disable iff (rst) read_i |-> !is_empty_o)
        else $error("circular_buffer: read while empty");

endmodule

// ==== verilog/downstream_vc_allocator.sv ====
`timescale 1ns/1ps

`include "noc_config.svh"

module downstream_vc_allocator
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       vc_request_i,
    input  logic                       vc_release_i,
    input  logic [`NOC_VC_NUM-1:0]     vc_busy_i,
    output logic                       vc_valid_o,
    output noc_flit_pkg::vc_id_t       vc_new_o
);

    logic                 held_q;
    noc_flit_pkg::vc_id_t held_vc_q;

    logic [`NOC_VC_NUM-1:0] free_vc;
    logic                   any_free;
    noc_flit_pkg::vc_id_t   lowest_free;

    // Scan from the top so the lowest free index is the one that sticks
    always_comb
    begin
        free_vc = ~vc_busy_i;
        if (held_q)
            free_vc[held_vc_q] = 1'b0; // Our own VC is not free to hand out again
        any_free    = 1'b0;
        lowest_free = '0;
        for (int i = `NOC_VC_NUM - 1; i >= 0; i--)
        begin
            if (free_vc[i])
            begin
                any_free    = 1'b1;
                lowest_free = noc_flit_pkg::vc_id_t'(i);
            end
        end
    end

    assign vc_valid_o = vc_request_i & any_free;
    assign vc_new_o   = lowest_free;

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
            held_q <= 1'b0;
        else if (vc_release_i)
            held_q <= 1'b0;
        else if (vc_valid_o)
            held_q <= 1'b1; // Grant takes effect on the same edge the buffer enters SA
    end

    always_ff @(posedge clk)
    begin
        if (vc_valid_o)
            held_vc_q <= vc_new_o;
    end

    a_release_held : assert property (@(posedge clk) disable iff (rst) vc_release_i |-> held_q)
        else $error("downstream_vc_allocator: release without a held VC");

    // The input buffer only asks again once the previous packet gave its VC back
    a_single_hold : assert property (@(posedge clk) disable iff (rst)
        vc_request_i |-> !held_q)
        else $error("downstream_vc_allocator: request while a VC is held");

endmodule

// ==== verilog/input_buffer.sv ====
`timescale 1ns/1ps

`include "noc_config.svh"

module input_buffer #(
    parameter int BUFFER_SIZE    = `NOC_BUFFER_SIZE,
    parameter int PIPELINE_DEPTH = `NOC_PIPELINE_DEPTH
)(
    input  logic                      clk,
    input  logic                      rst,
    input  noc_flit_pkg::flit_label_t flit_label_i,
    input  noc_flit_pkg::payload_t    payload_i,
    input  logic                      write_i,
    input  logic                      read_i,
    input  noc_route_pkg::port_t      out_port_i,
    input  logic                      vc_valid_i,
    input  noc_flit_pkg::vc_id_t      vc_new_i,
    output noc_flit_pkg::flit_label_t flit_label_o,
    output noc_flit_pkg::payload_t    payload_o,
    output noc_flit_pkg::vc_id_t      vc_id_o,
    output noc_route_pkg::port_t      out_port_o,
    output logic                      is_full_o,
    output logic                      is_empty_o,
    output logic                      on_off_o,
    output logic                      vc_request_o,
    output logic                      switch_request_o,
    output logic                      vc_allocatable_o,
    output logic                      error_o
);

    typedef enum logic [1:0]
    {
        IDLE,
        VA,
        SA
    } state_t;

    state_t state;
    state_t state_next;

    noc_route_pkg::port_t out_port_next;
    noc_flit_pkg::vc_id_t vc_id_next;

    logic write_cmd;
    logic read_cmd;
    logic vc_allocatable_next;
    logic error_next;

    logic write_head;
    logic write_data;
    logic write_bad;

    assign write_head = write_i & (flit_label_i == noc_flit_pkg::HEAD);
    assign write_data = write_i & ((flit_label_i == noc_flit_pkg::BODY) |
                                   (flit_label_i == noc_flit_pkg::TAIL));
    assign write_bad  = write_i & (flit_label_i == noc_flit_pkg::HEADTAIL);

    circular_buffer #(
        .BUFFER_SIZE    (BUFFER_SIZE),
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) i_fifo (
        .clk          (clk),
        .rst          (rst),
        .write_i      (write_cmd),
        .read_i       (read_cmd),
        .flit_label_i (flit_label_i),
        .payload_i    (payload_i),
        .flit_label_o (flit_label_o),
        .payload_o    (payload_o),
        .is_full_o    (is_full_o),
        .is_empty_o   (is_empty_o),
        .on_off_o     (on_off_o)
    );

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            state            <= IDLE;
            out_port_o       <= noc_route_pkg::LOCAL;
            vc_id_o          <= '0;
            vc_allocatable_o <= 1'b0;
            error_o          <= 1'b0;
        end
        else
        begin
            state            <= state_next;
            out_port_o       <= out_port_next;
            vc_id_o          <= vc_id_next;
            vc_allocatable_o <= vc_allocatable_next; // One cycle pulse after the tail leaves
            error_o          <= error_next;
        end
    end

    always_comb
    begin
        state_next          = state;
        out_port_next       = out_port_o;
        vc_id_next          = vc_id_o;
        write_cmd           = 1'b0;
        read_cmd            = 1'b0;
        vc_request_o        = 1'b0;
        switch_request_o    = 1'b0;
        vc_allocatable_next = 1'b0;
        error_next          = write_bad; // HEADTAIL is never legal here

        case (state)
            IDLE:
            begin
                if (write_head & is_empty_o)
                begin
                    write_cmd     = 1'b1;
                    out_port_next = out_port_i; // Route belongs to the whole packet
                    state_next    = VA;
                end
                if (write_data | (write_head & ~is_empty_o) | read_i | vc_valid_i)
                    error_next = 1'b1;
            end

            VA:
            begin
                vc_request_o = 1'b1;
                write_cmd    = write_data; // Body flits keep streaming in meanwhile
                if (vc_valid_i)
                begin
                    vc_id_next = vc_new_i;
                    state_next = SA;
                end
                if (write_head | read_i)
                    error_next = 1'b1;
            end

            SA:
            begin
                switch_request_o = 1'b1;
                write_cmd        = write_data;
                read_cmd         = read_i;
                if (read_i & ~is_empty_o & (flit_label_o == noc_flit_pkg::TAIL))
                begin
                    vc_allocatable_next = 1'b1;
                    state_next          = IDLE;
                end
                if (write_head | vc_valid_i)
                    error_next = 1'b1;
            end

            default:
            begin
                state_next = IDLE; // Recover from a corrupted state register
                error_next = 1'b1;
            end
        endcase
    end

    // VA and SA are exclusive phases of one packet
    a_one_request : assert property (@(posedge clk) disable iff (rst)
        !(switch_request_o && vc_request_o))
        else $error("input_buffer: VC and switch requested together");

endmodule

// ==== verilog/noc_flit_pkg.sv ====
`include "noc_config.svh"

package noc_flit_pkg;

    // HEADTAIL is decoded but never accepted by the input port
    typedef enum logic [1:0]
    {
        HEAD,
        BODY,
        TAIL,
        HEADTAIL
    } flit_label_t;

    typedef logic [`NOC_PAYLOAD_WIDTH-1:0] payload_t;

    typedef logic [`NOC_VC_SIZE-1:0] vc_id_t;

endpackage

// ==== verilog/noc_route_pkg.sv ====
`include "noc_config.svh"

package noc_route_pkg;

    typedef enum logic [2:0]
    {
        LOCAL,
        NORTH,
        SOUTH,
        WEST,
        EAST
    } port_t;

    typedef logic [`NOC_COORD_WIDTH-1:0] coord_t;

endpackage

// ==== verilog/router_input_port.sv ====
`timescale 1ns/1ps

`include "noc_config.svh"

module router_input_port
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flit_write_i,
    input  noc_flit_pkg::flit_label_t flit_label_i,
    input  noc_flit_pkg::payload_t    payload_i,
    input  logic                      sw_grant_i,
    input  logic [`NOC_VC_NUM-1:0]    vc_busy_i,
    output noc_flit_pkg::flit_label_t flit_label_o,
    output noc_flit_pkg::payload_t    payload_o,
    output noc_flit_pkg::vc_id_t      vc_id_o,
    output noc_route_pkg::port_t      out_port_o,
    output logic                      switch_request_o,
    output logic                      on_off_o,
    output logic                      is_full_o,
    output logic                      is_empty_o,
    output logic                      error_o
);

    noc_route_pkg::port_t route_port;
    logic                 vc_request;
    logic                 vc_valid;
    noc_flit_pkg::vc_id_t vc_new;
    logic                 vc_allocatable;

    xy_route_compute i_route (
        .flit_label_i (flit_label_i),
        .payload_i    (payload_i),
        .out_port_o   (route_port)
    );

    input_buffer #(
        .BUFFER_SIZE    (`NOC_BUFFER_SIZE),
        .PIPELINE_DEPTH (`NOC_PIPELINE_DEPTH)
    ) i_input_buffer (
        .clk              (clk),
        .rst              (rst),
        .flit_label_i     (flit_label_i),
        .payload_i        (payload_i),
        .write_i          (flit_write_i),
        .read_i           (sw_grant_i),     // Each switch grant pops one flit
        .out_port_i       (route_port),
        .vc_valid_i       (vc_valid),
        .vc_new_i         (vc_new),
        .flit_label_o     (flit_label_o),
        .payload_o        (payload_o),
        .vc_id_o          (vc_id_o),
        .out_port_o       (out_port_o),
        .is_full_o        (is_full_o),
        .is_empty_o       (is_empty_o),
        .on_off_o         (on_off_o),
        .vc_request_o     (vc_request),
        .switch_request_o (switch_request_o),
        .vc_allocatable_o (vc_allocatable),
        .error_o          (error_o)
    );

    downstream_vc_allocator i_vc_alloc (
        .clk          (clk),
        .rst          (rst),
        .vc_request_i (vc_request),
        .vc_release_i (vc_allocatable),
        .vc_busy_i    (vc_busy_i),
        .vc_valid_o   (vc_valid),
        .vc_new_o     (vc_new)
    );

endmodule

// ==== verilog/xy_route_compute.sv ====
`timescale 1ns/1ps

`include "noc_config.svh"

module xy_route_compute
(
    input  noc_flit_pkg::flit_label_t flit_label_i,
    input  noc_flit_pkg::payload_t    payload_i,
    output noc_route_pkg::port_t      out_port_o
);

    localparam int W = `NOC_COORD_WIDTH;

    localparam noc_route_pkg::coord_t LOCAL_X = `NOC_LOCAL_X;
    localparam noc_route_pkg::coord_t LOCAL_Y = `NOC_LOCAL_Y;

    noc_route_pkg::coord_t dest_x;
    noc_route_pkg::coord_t dest_y;

    assign dest_x = payload_i[2*W-1:W]; // Destination column sits above the row
    assign dest_y = payload_i[W-1:0];

    // X is resolved completely before Y, which keeps the mesh deadlock free
    always_comb
    begin
        out_port_o = noc_route_pkg::LOCAL;
        if (flit_label_i == noc_flit_pkg::HEAD)
        begin
            if (dest_x > LOCAL_X)
                out_port_o = noc_route_pkg::EAST;
            else if (dest_x < LOCAL_X)
                out_port_o = noc_route_pkg::WEST;
            else if (dest_y > LOCAL_Y)
                out_port_o = noc_route_pkg::NORTH;
            else if (dest_y < LOCAL_Y)
                out_port_o = noc_route_pkg::SOUTH;
            else
                out_port_o = noc_route_pkg::LOCAL; // Packet has arrived
        end
    end

endmodule
